// ==== Bender.yml ====
package:
  name: cache_subsystem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/inst_cache.sv
      - verilog/data_cache.sv
      - verilog/mem_arbiter.sv
      - verilog/cache_subsystem.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/slow_mem_model.sv
      - sim/tb_cache_subsystem.sv

// ==== sim.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/inst_cache.sv
verilog/data_cache.sv
verilog/mem_arbiter.sv
verilog/cache_subsystem.sv
sim/slow_mem_model.sv
sim/tb_cache_subsystem.sv

// ==== sim/slow_mem_model.sv ====
// simulation only; 64 lines, so line addresses above 63 alias, one request at a time
`timescale 1ns/1ps
`include "cache_defs.svh"

module slow_mem_model #(
	parameter int LATENCY = 4   // cycles from request to ready (1 or more)
) (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::mem_rsp_t rsp
);
	import cache_pkg::*;

	logic [`LINE_W-1:0] mem [64];
	logic [`LINE_W-1:0] rdata;
	logic               ready;
	int                 cnt;
	logic [5:0]         idx;

	assign idx = req.addr[5:0];
	assign rsp = '{rdata: rdata, ready: ready};

	// word w of line l holds its own word address xor a constant
	initial begin
		for (int l = 0; l < 64; l++) begin
			for (int w = 0; w < 4; w++) begin
				mem[l][w*`WORD_W +: `WORD_W] = (l * 4 + w) ^ 32'h1357_9bdf;
			end
		end
	end

	always @(posedge clk) begin
		if (proc_reset) begin
			cnt   <= 0;
			ready <= 1'b0;
			rdata <= '0;
		end else begin
			ready <= 1'b0;   // one-cycle pulse
			if ((req.read || req.write) && !ready) begin
				if (cnt == LATENCY - 1) begin
					cnt   <= 0;
					ready <= 1'b1;
					rdata <= mem[idx];
					if (req.write) begin
						mem[idx] <= req.wdata;
					end
				end else begin
					cnt <= cnt + 1;
				end
			end
		end
	end

endmodule

// ==== sim/tb_cache_subsystem.sv ====
// ifetch stays below word 64 and data writes above it; all addresses below 256 for the model
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache_subsystem;
	import cache_pkg::*;

	localparam int MEM_LAT  = 4;
	localparam int N_ACC    = 40;                       // upper bound on accesses below
	localparam int MISS_CYC = 2 * (MEM_LAT + 2) + 8;    // write-back, fill, slack
	localparam int MAX_CYC  = 10 + N_ACC * MISS_CYC;

	logic               clk;
	logic               proc_reset;
	cpu_req_t           ic_req;
	cpu_req_t           dc_req;
	cpu_rsp_t           ic_rsp;
	cpu_rsp_t           dc_rsp;
	mem_req_t           mem_req;
	mem_rsp_t           mem_rsp;
	logic [`WORD_W-1:0] ic_exp;
	logic [`WORD_W-1:0] dc_exp;
	logic               ic_hit_exp;   // repeated fetch must not stall
	logic               ic_done;
	logic               dc_done;
	logic [`WORD_W-1:0] shadow [256];
	integer             seed;
	int                 n_mismatch;
	int                 n_fail;
	int                 cycles = 0;
	logic [29:0]        fetch_list [6] = '{30'd0, 30'd1, 30'd5, 30'd20, 30'd37, 30'd62};

	cache_subsystem uut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.ic_req     (ic_req),
		.ic_rsp     (ic_rsp),
		.dc_req     (dc_req),
		.dc_rsp     (dc_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	slow_mem_model #(.LATENCY(MEM_LAT)) u_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (mem_req),
		.rsp        (mem_rsp)
	);

	always #4 clk = ~clk;

	// completion seen at the edge and read back at the next falling edge
	always @(posedge clk) begin
		ic_done <= ic_req.read && !ic_rsp.stall;
		dc_done <= (dc_req.read || dc_req.write) && !dc_rsp.stall;
		cycles  <= cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("timeout after %0d cycles, an access never completed", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	a_reset_idle: assert property (@(posedge clk) $fell(proc_reset) |->
		(!mem_req.read && !mem_req.write && !ic_rsp.stall && !dc_rsp.stall))
		else report_failure("stall or memory request active right after reset");
	a_ic_idle: assert property (@(posedge clk) disable iff (proc_reset)
		!ic_req.read |-> !ic_rsp.stall)
		else report_failure("instruction cache stalled with no request");
	a_dc_idle: assert property (@(posedge clk) disable iff (proc_reset)
		!(dc_req.read || dc_req.write) |-> !dc_rsp.stall)
		else report_failure("data cache stalled with no request");
	a_ic_hit: assert property (@(posedge clk) disable iff (proc_reset)
		(ic_req.read && ic_hit_exp) |-> !ic_rsp.stall)
		else report_failure("repeated fetch did not hit");
	a_mem_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
		else report_failure("memory read and write high together");
	a_ic_data: assert property (@(posedge clk) disable iff (proc_reset)
		(ic_req.read && !ic_rsp.stall) |-> (ic_rsp.rdata == ic_exp))
		else begin
			n_mismatch++;
			$display("MISMATCH t=%0t ic_rsp.rdata expected %h got %h",
				$time, $sampled(ic_exp), $sampled(ic_rsp.rdata));
		end
	a_dc_data: assert property (@(posedge clk) disable iff (proc_reset)
		(dc_req.read && !dc_rsp.stall) |-> (dc_rsp.rdata == dc_exp))
		else begin
			n_mismatch++;
			$display("MISMATCH t=%0t dc_rsp.rdata expected %h got %h",
				$time, $sampled(dc_exp), $sampled(dc_rsp.rdata));
		end

	// protocol failures other than a wrong data value
	task automatic report_failure(input string what);
		n_fail++;
		$display("t=%0t %s", $time, what);
	endtask

	function automatic logic [`WORD_W-1:0] pattern_of(input int a);
		return a ^ 32'h1357_9bdf;
	endfunction

	// called at a falling edge and returns at the falling edge after completion
	task automatic fetch_word(input logic [29:0] a, input logic hit);
		ic_req.read = 1'b1;
		ic_req.addr = a;
		ic_exp      = pattern_of(a);
		ic_hit_exp  = hit;
		do @(negedge clk); while (!ic_done);
		ic_req     = '0;
		ic_hit_exp = 1'b0;
	endtask

	task automatic data_access(input logic wr, input logic [29:0] a);
		logic [`WORD_W-1:0] d;
		d            = $random(seed);
		dc_req.read  = !wr;
		dc_req.write = wr;
		dc_req.addr  = a;
		dc_req.wdata = d;
		dc_exp       = shadow[a[7:0]];
		do @(negedge clk); while (!dc_done);
		if (wr) begin
			shadow[a[7:0]] = d;   // write lands at the completing edge
		end
		dc_req = '0;
	endtask

	initial begin
		clk        = 1'b0;
		proc_reset = 1'b1;
		ic_req     = '0;
		dc_req     = '0;
		ic_exp     = '0;
		dc_exp     = '0;
		ic_hit_exp = 1'b0;
		seed       = 32'ha2c3_ca72;
		n_mismatch = 0;
		n_fail     = 0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = pattern_of(i);
		end
		repeat (10) @(negedge clk);
		proc_reset = 1'b0;
		repeat (3) @(negedge clk);   // idle after reset

		// ------------------------------
		foreach (fetch_list[i]) begin
			fetch_word(fetch_list[i], 1'b0);
			fetch_word(fetch_list[i], 1'b1);
		end
		data_access(1'b1, 30'd100);
		data_access(1'b0, 30'd100);
		data_access(1'b0, 30'd101);   // never written
		data_access(1'b0, 30'd130);
		// tags 8 9 10 in set 2 force dirty evictions
		data_access(1'b1, 30'd136);
		data_access(1'b1, 30'd152);
		data_access(1'b1, 30'd168);
		data_access(1'b1, 30'd170);
		data_access(1'b0, 30'd136);
		data_access(1'b0, 30'd152);
		data_access(1'b0, 30'd168);
		data_access(1'b0, 30'd170);

		// ------------------------------
		// both caches missing together
		fork
			fetch_word(30'd44, 1'b0);
			data_access(1'b0, 30'd232);
		join
		fork
			fetch_word(30'd44, 1'b1);
			data_access(1'b1, 30'd250);
		join
		fork
			fetch_word(30'd60, 1'b0);
			data_access(1'b0, 30'd250);
		join
		data_access(1'b0, 30'd136);
		data_access(1'b0, 30'd168);

		repeat (2) @(negedge clk);
		$display("checks done: %0d mismatches, %0d other failures", n_mismatch, n_fail);
		if (n_mismatch == 0 && n_fail == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/cache_defs.svh ====
// widths assume 2 ways x 4 sets of 128-bit lines; cache_pkg types follow them
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// processor side
`define WORD_ADDR_W 30   // word address without the byte offset
`define WORD_W      32
`define WORD_SEL_W  2    // four words per line

// memory side
`define LINE_W      128
`define LINE_ADDR_W 28

// tag and index split of the word address
`define TAG_W       26
`define SET_W       2
`define N_SETS      4

`endif

// ==== verilog/cache_pkg.sv ====
// shared request, response and line types; all widths come from cache_defs.svh
`include "cache_defs.svh"

package cache_pkg;

	// lookup view of a word address
	typedef struct packed {
		logic [`TAG_W-1:0]      tag;
		logic [`SET_W-1:0]      set;
		logic [`WORD_SEL_W-1:0] wsel;
	} addr_fields_t;

	// fill view with the line address in the upper bits
	typedef struct packed {
		logic [`LINE_ADDR_W-1:0] line;
		logic [`WORD_SEL_W-1:0]  wsel;
	} line_view_t;

	typedef union packed {
		addr_fields_t fields;
		line_view_t   lview;
	} proc_addr_u;

	typedef struct packed {
		logic               read;
		logic               write;
		proc_addr_u         addr;
		logic [`WORD_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic               stall;
		logic [`WORD_W-1:0] rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic                    read;
		logic                    write;
		logic [`LINE_ADDR_W-1:0] addr;
		logic [`LINE_W-1:0]      wdata;
	} mem_req_t;

	typedef struct packed {
		logic [`LINE_W-1:0] rdata;
		logic               ready;
	} mem_rsp_t;

	typedef struct packed {
		logic               lru;    // set on fill, cleared on the other way
		logic               valid;
		logic               dirty;  // stays 0 in the instruction cache
		logic [`TAG_W-1:0]  tag;
		logic [`LINE_W-1:0] data;
	} cache_line_t;

endpackage

// ==== verilog/cache_subsystem.sv ====
// two caches on one shared line port; no request may change while its stall is high
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_subsystem (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::cpu_req_t ic_req,
	output cache_pkg::cpu_rsp_t ic_rsp,
	input  cache_pkg::cpu_req_t dc_req,
	output cache_pkg::cpu_rsp_t dc_rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	mem_req_t ic_mem_req;
	mem_req_t dc_mem_req;
	mem_rsp_t ic_mem_rsp;
	mem_rsp_t dc_mem_rsp;

	// union views must cover exactly one word address
	if ($bits(proc_addr_u) != `WORD_ADDR_W) begin : g_addr_check
		$error("proc_addr_u does not match the word address width");
	end

	inst_cache u_inst_cache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (ic_req),
		.rsp        (ic_rsp),
		.mem_req    (ic_mem_req),
		.mem_rsp    (ic_mem_rsp)
	);

	data_cache u_data_cache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (dc_req),
		.rsp        (dc_rsp),
		.mem_req    (dc_mem_req),
		.mem_rsp    (dc_mem_rsp)
	);

	mem_arbiter u_mem_arbiter (
		.clk        (clk),
		.proc_reset (proc_reset),
		.ic_req     (ic_mem_req),
		.dc_req     (dc_mem_req),
		.ic_rsp     (ic_mem_rsp),
		.dc_rsp     (dc_mem_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

endmodule

// ==== verilog/data_cache.sv ====
// write-back, write-allocate; a dirty victim goes to memory before the fill, hits keep lru as is
`timescale 1ns/1ps
`include "cache_defs.svh"

module data_cache (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::cpu_req_t req,
	output cache_pkg::cpu_rsp_t rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		S_COMPARE,
		S_WRITE_BACK,
		S_ALLOCATE
	} state_t;

	state_t                 state;
	cache_line_t            way [2][`N_SETS];   // [way][set]
	cache_line_t            vline;              // replacement candidate in this set
	logic [`SET_W-1:0]      set;
	logic [`WORD_SEL_W-1:0] wsel;
	logic [1:0]             hit;
	logic                   hit_way;
	logic                   miss;
	logic                   victim;

	assign set     = req.addr.fields.set;
	assign wsel    = req.addr.fields.wsel;
	assign victim  = way[0][set].lru;           // lru clear marks the way to replace
	assign vline   = way[victim][set];
	assign hit_way = hit[1];
	assign miss    = (req.read || req.write) && (hit == 2'b00);

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = way[w][set].valid && (way[w][set].tag == req.addr.fields.tag);
		end
	end

	// ------------------------------
	// processor and memory outputs
	// ------------------------------
	always_comb begin
		rsp     = '0;
		mem_req = '0;
		case (state)
			S_COMPARE: begin
				rsp.stall = miss;
				if (!miss) begin
					rsp.rdata = way[hit_way][set].data[wsel*`WORD_W +: `WORD_W];
				end
			end
			S_WRITE_BACK: begin
				rsp.stall     = 1'b1;
				mem_req.write = 1'b1;
				mem_req.addr  = {vline.tag, set};   // victim's own line
				mem_req.wdata = vline.data;
			end
			S_ALLOCATE: begin
				rsp.stall    = 1'b1;
				mem_req.read = 1'b1;
				mem_req.addr = req.addr.lview.line;
			end
			default: begin
				rsp.stall = 1'b1;
			end
		endcase
	end

	// ------------------------------
	// line state and FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= S_COMPARE;
			for (int s = 0; s < `N_SETS; s++) begin
				for (int w = 0; w < 2; w++) begin
					way[w][s].lru   <= 1'b0;
					way[w][s].valid <= 1'b0;
					way[w][s].dirty <= 1'b0;
				end
			end
		end else begin
			case (state)
				S_COMPARE: begin
					if (miss) begin
						state <= vline.dirty ? S_WRITE_BACK : S_ALLOCATE;
					end else if (req.write) begin
						// write hit updates the word in place
						way[hit_way][set].data[wsel*`WORD_W +: `WORD_W] <= req.wdata;
						way[hit_way][set].dirty <= 1'b1;
					end
				end
				S_WRITE_BACK: begin
					if (mem_rsp.ready) begin
						way[victim][set].dirty <= 1'b0;   // memory copy now current
						state <= S_ALLOCATE;
					end
				end
				S_ALLOCATE: begin
					if (mem_rsp.ready) begin
						way[victim][set] <= '{lru: 1'b1, valid: 1'b1, dirty: 1'b0,
							tag: req.addr.fields.tag, data: mem_rsp.rdata};
						way[!victim][set].lru <= 1'b0;
						state <= S_COMPARE;
					end
				end
				default: begin
					state <= S_COMPARE;
				end
			endcase
		end
	end

	// ------------------------------
	a_rw_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
		else $error("data_cache: read and write together on mem_req");
	// write-back only ends on the memory's ready
	a_wb_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(state == S_WRITE_BACK && !mem_rsp.ready) |=> (state == S_WRITE_BACK))
		else $error("data_cache: left write_back without ready");

endmodule

// ==== verilog/inst_cache.sv ====
// read-only, so req.write and req.wdata are ignored; req must be held while stall is high
`timescale 1ns/1ps
`include "cache_defs.svh"

module inst_cache (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::cpu_req_t req,
	output cache_pkg::cpu_rsp_t rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	typedef enum logic {
		S_COMPARE,
		S_ALLOCATE
	} state_t;

	state_t                 state;
	cache_line_t            way [2][`N_SETS];   // [way][set]
	logic [`SET_W-1:0]      set;
	logic [`WORD_SEL_W-1:0] wsel;
	logic [1:0]             hit;
	logic                   miss;
	logic                   victim;             // way whose lru bit is clear

	assign set    = req.addr.fields.set;
	assign wsel   = req.addr.fields.wsel;
	assign victim = way[0][set].lru;
	assign miss   = req.read && (hit == 2'b00);

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = way[w][set].valid && (way[w][set].tag == req.addr.fields.tag);
		end
	end

	// ------------------------------
	// processor and memory outputs
	// ------------------------------
	always_comb begin
		rsp     = '0;
		mem_req = '0;
		case (state)
			S_COMPARE: begin
				rsp.stall = miss;
				if (!miss) begin
					rsp.rdata = way[hit[1]][set].data[wsel*`WORD_W +: `WORD_W];
				end
			end
			S_ALLOCATE: begin
				rsp.stall    = 1'b1;
				mem_req.read = 1'b1;                  // held through the ready cycle
				mem_req.addr = req.addr.lview.line;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= S_COMPARE;
			for (int s = 0; s < `N_SETS; s++) begin
				for (int w = 0; w < 2; w++) begin
					way[w][s].lru   <= 1'b0;
					way[w][s].valid <= 1'b0;
					way[w][s].dirty <= 1'b0;
				end
			end
		end else begin
			case (state)
				S_COMPARE: begin
					if (miss) begin
						state <= S_ALLOCATE;
					end
				end
				S_ALLOCATE: begin
					if (mem_rsp.ready) begin
						way[victim][set] <= '{lru: 1'b1, valid: 1'b1, dirty: 1'b0,
							tag: req.addr.fields.tag, data: mem_rsp.rdata};
						way[!victim][set].lru <= 1'b0;
						state <= S_COMPARE;
					end
				end
			endcase
		end
	end

	// ------------------------------
	a_no_write: assert property (@(posedge clk) disable iff (proc_reset) !mem_req.write)
		else $error("inst_cache: write on mem_req");
	// held request hits right after its fill
	a_fill_hits: assert property (@(posedge clk) disable iff (proc_reset)
		(state == S_ALLOCATE && mem_rsp.ready) |=> !rsp.stall)
		else $error("inst_cache: still stalled after fill");

endmodule

// ==== verilog/mem_arbiter.sv ====
// data cache has fixed priority and holds the grant until ready; data misses can delay ifetch
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::mem_req_t ic_req,
	input  cache_pkg::mem_req_t dc_req,
	output cache_pkg::mem_rsp_t ic_rsp,
	output cache_pkg::mem_rsp_t dc_rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);

	typedef enum logic {
		OWN_IC,
		OWN_DC
	} owner_t;

	logic   busy;      // grant locked while a transfer is in flight
	owner_t owner;
	owner_t sel;
	logic   dc_want;

	assign dc_want = dc_req.read || dc_req.write;
	assign sel     = busy ? owner : (dc_want ? OWN_DC : OWN_IC);
	assign mem_req = (sel == OWN_DC) ? dc_req : ic_req;

	// rdata fans out to both and only ready is steered
	always_comb begin
		ic_rsp       = mem_rsp;
		dc_rsp       = mem_rsp;
		ic_rsp.ready = mem_rsp.ready && (sel == OWN_IC);
		dc_rsp.ready = mem_rsp.ready && (sel == OWN_DC);
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			busy  <= 1'b0;
			owner <= OWN_IC;
		end else begin
			busy  <= (mem_req.read || mem_req.write) && !mem_rsp.ready;  // free on ready
			owner <= sel;
		end
	end

	// ------------------------------
	a_one_ready: assert property (@(posedge clk) disable iff (proc_reset)
		!(ic_rsp.ready && dc_rsp.ready))
		else $error("mem_arbiter: ready sent to both caches");
	// granted cache keeps its address until ready
	a_addr_hold: assert property (@(posedge clk) disable iff (proc_reset)
		((mem_req.read || mem_req.write) && !mem_rsp.ready) |=> $stable(mem_req.addr))
		else $error("mem_arbiter: address changed during a transfer");

endmodule
